/* Makefile */
TOP := acc_cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f acc_cpu.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f acc_cpu.f

clean:
	rm -rf obj_dir

/* acc_cpu.f */
design/bus_pkg.sv
design/isa_pkg.sv
design/bus_sequencer.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_stage.sv
design/acc_cpu.sv
verification/tb_memory.sv
verification/acc_cpu_tb.sv

/* design/acc_cpu.sv */
`timescale 1ns/1ns

module acc_cpu (
    input  logic             clk,
    input  logic             rst_n,
    output bus_pkg::wb_req_t wb_req,
    input  bus_pkg::wb_rsp_t wb_rsp,
    output logic             halted
);

    // held instruction from the fetch
    isa_pkg::instr_t            instr;
    // decoded controls
    isa_pkg::ctrl_t             ctrl;
    // read word from the data cycle
    logic [bus_pkg::data_w-1:0] mem_data;
    logic [bus_pkg::data_w-1:0] alu_result;
    // architectural state fed back to the sequencer
    logic [bus_pkg::data_w-1:0] acc;
    logic [bus_pkg::addr_w-1:0] pc;
    // end of instruction
    logic                       commit;

    // bus cycles, ir and mbr
    bus_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .ctrl     (ctrl),
        .pc       (pc),
        .acc      (acc),
        .halted   (halted),
        .instr    (instr),
        .mem_data (mem_data),
        .commit   (commit)
    );

    instr_decode u_dec (
        .instr (instr),
        .ctrl  (ctrl)
    );

    alu_execute u_exe (
        .ctrl       (ctrl),
        .acc        (acc),
        .mem_data   (mem_data),
        .alu_result (alu_result)
    );

    // acc, pc and halt flag
    result_stage u_res (
        .clk        (clk),
        .rst_n      (rst_n),
        .commit     (commit),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .acc        (acc),
        .pc         (pc),
        .halted     (halted)
    );

endmodule

/* design/alu_execute.sv */
`timescale 1ns/1ns

module alu_execute (
    input  isa_pkg::ctrl_t               ctrl,
    input  logic [bus_pkg::data_w-1:0]   acc,
    input  logic [bus_pkg::data_w-1:0]   mem_data,
    output logic [bus_pkg::data_w-1:0]   alu_result
);

    // second operand from the immediate or the memory word
    logic [bus_pkg::data_w-1:0] opnd_b;
    // raw alu output before the load bypass
    logic [bus_pkg::data_w-1:0] alu_out;

    // zero-extend the 8-bit immediate
    assign opnd_b = ctrl.use_imm ? {{(bus_pkg::data_w - isa_pkg::imm_w){1'b0}}, ctrl.imm}
                                 : mem_data;

    // addm arrives here already decoded as add
    always_comb begin
        case (ctrl.alu_op)
            isa_pkg::op_add:  alu_out = acc + opnd_b;
            isa_pkg::op_sub:  alu_out = acc - opnd_b;
            // low half of the product only
            isa_pkg::op_mul:  alu_out = acc * opnd_b;
            // unsigned divide with all ones for a zero divisor
            isa_pkg::op_div: begin
                if (opnd_b == '0) begin
                    alu_out = '1;
                end else begin
                    alu_out = acc / opnd_b;
                end
            end
            isa_pkg::op_shl1: alu_out = {acc[bus_pkg::data_w-2:0], 1'b0};
            isa_pkg::op_shr1: alu_out = {1'b0, acc[bus_pkg::data_w-1:1]};
            isa_pkg::op_rol1: alu_out = {acc[bus_pkg::data_w-2:0], acc[bus_pkg::data_w-1]};
            isa_pkg::op_ror1: alu_out = {acc[0], acc[bus_pkg::data_w-1:1]};
            isa_pkg::op_and:  alu_out = acc & opnd_b;
            isa_pkg::op_or:   alu_out = acc | opnd_b;
            isa_pkg::op_xor:  alu_out = acc ^ opnd_b;
            isa_pkg::op_nor:  alu_out = ~(acc | opnd_b);
            isa_pkg::op_nand: alu_out = ~(acc & opnd_b);
            isa_pkg::op_xnor: alu_out = ~(acc ^ opnd_b);
            // unsigned compares giving 1 or 0
            isa_pkg::op_gt:   alu_out = (acc > opnd_b) ? 16'd1 : 16'd0;
            isa_pkg::op_eq:   alu_out = (acc == opnd_b) ? 16'd1 : 16'd0;
            default:          alu_out = '0;
        endcase
    end

    // load passes the memory word straight through
    assign alu_result = (ctrl.major == isa_pkg::maj_load) ? mem_data : alu_out;

endmodule

/* design/bus_pkg.sv */
package bus_pkg;

    // word width on the bus, also the instruction width
    localparam int data_w = 16;
    // word address, 4096 words of main memory
    localparam int addr_w = 12;

    // master to slave, wishbone classic
    typedef struct packed {
        // cycle and strobe rise and fall together in this core
        logic              cyc;
        logic              stb;
        // high for a write cycle
        logic              we;
        logic [addr_w-1:0] adr;
        // write data, ignored by the slave on reads
        logic [data_w-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        // one cycle wide, low during wait states
        logic              ack;
        // read data, valid with ack
        logic [data_w-1:0] dat;
    } wb_rsp_t;

endpackage

/* design/bus_sequencer.sv */
`timescale 1ns/1ns

module bus_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    output bus_pkg::wb_req_t              wb_req,
    input  bus_pkg::wb_rsp_t              wb_rsp,
    input  isa_pkg::ctrl_t                ctrl,
    input  logic [bus_pkg::addr_w-1:0]    pc,
    input  logic [bus_pkg::data_w-1:0]    acc,
    input  logic                          halted,
    output isa_pkg::instr_t               instr,
    output logic [bus_pkg::data_w-1:0]    mem_data,
    output logic                          commit
);

    // one instruction at a time with no overlap
    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_halt
    } state_e;

    state_e                      state;
    // drives both cyc and stb
    logic                        bus_act;
    // instruction register
    isa_pkg::instr_t             ir_q;
    // memory buffer register for read data
    logic [bus_pkg::data_w-1:0]  mbr_q;
    // ack sampled while our cycle is open
    logic                        bus_done;

    assign bus_done = bus_act && wb_rsp.ack;

    // commit in execute when no data cycle is needed
    // or in the idle cycle after the data ack
    assign commit = ((state == st_exec) && !ctrl.needs_mem) ||
                    ((state == st_mem) && !bus_act);

    assign instr    = ir_q;
    assign mem_data = mbr_q;

    // request fields come from registers only
    // so they hold steady through wait states
    always_comb begin
        wb_req.cyc = bus_act;
        wb_req.stb = bus_act;
        wb_req.we  = (state == st_mem) && ctrl.mem_write;
        // fetch at pc and data cycle at the held instruction's address
        wb_req.adr = (state == st_mem) ? ctrl.addr : pc;
        // acc only changes on commit
        wb_req.dat = acc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_fetch;
            bus_act <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (bus_done) begin
                        // drop stb right after ack
                        bus_act <= 1'b0;
                        state   <= st_exec;
                    end else if (!bus_act && halted) begin
                        state <= st_halt;
                    end else if (!bus_act) begin
                        // first fetch after reset release
                        bus_act <= 1'b1;
                    end
                end
                st_exec: begin
                    if (commit) begin
                        // next fetch starts the cycle after commit
                        // pc already updated by then
                        state   <= st_fetch;
                        bus_act <= !ctrl.is_halt;
                    end else begin
                        // execute cycle was the idle gap
                        state   <= st_mem;
                        bus_act <= 1'b1;
                    end
                end
                st_mem: begin
                    if (bus_done) begin
                        bus_act <= 1'b0;
                    end else if (commit) begin
                        // memory classes never halt
                        state   <= st_fetch;
                        bus_act <= 1'b1;
                    end
                end
                st_halt: begin
                    // parked until reset with the bus idle
                end
            endcase
        end
    end

    // payload registers loaded on ack
    always_ff @(posedge clk) begin
        if ((state == st_fetch) && bus_done) begin
            ir_q <= wb_rsp.dat;
        end
        // capture on reads only since a write ack carries no data
        if ((state == st_mem) && bus_done && !ctrl.mem_write) begin
            mbr_q <= wb_rsp.dat;
        end
    end

endmodule

/* design/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode (
    input  isa_pkg::instr_t instr,
    output isa_pkg::ctrl_t  ctrl
);

    always_comb begin
        // all controls off by default so a no-op just advances pc
        ctrl = '0;
        // class sits in the same bits in both views
        ctrl.major = instr.alu.major;

        case (instr.alu.major)
            isa_pkg::maj_alu_imm: begin
                // alu view of the word
                ctrl.alu_op     = instr.alu.op;
                ctrl.use_imm    = 1'b1;
                ctrl.imm        = instr.alu.imm;
                ctrl.writes_acc = 1'b1;
            end
            isa_pkg::maj_load: begin
                // memory view from here on
                ctrl.addr       = instr.mem.addr;
                ctrl.needs_mem  = 1'b1;
                ctrl.writes_acc = 1'b1;
            end
            isa_pkg::maj_store: begin
                ctrl.addr      = instr.mem.addr;
                ctrl.needs_mem = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            isa_pkg::maj_jump: begin
                ctrl.addr    = instr.mem.addr;
                ctrl.is_jump = 1'b1;
            end
            isa_pkg::maj_jz: begin
                // taken or not is resolved at commit
                ctrl.addr  = instr.mem.addr;
                ctrl.is_jz = 1'b1;
            end
            isa_pkg::maj_addm: begin
                // acc plus the memory word
                ctrl.alu_op     = isa_pkg::op_add;
                ctrl.addr       = instr.mem.addr;
                ctrl.needs_mem  = 1'b1;
                ctrl.writes_acc = 1'b1;
            end
            isa_pkg::maj_halt: begin
                ctrl.is_halt = 1'b1;
            end
            default: begin
                // unknown class keeps the defaults
            end
        endcase
    end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

    // field widths of the 16-bit instruction word
    localparam int major_w = 4;
    localparam int op_w    = 4;
    localparam int imm_w   = 8;

    // instruction class, top nibble of every word
    // unlisted codes run as a no-op
    typedef enum logic [major_w-1:0] {
        maj_alu_imm = 4'h0,
        maj_load    = 4'h1,
        maj_store   = 4'h2,
        maj_jump    = 4'h3,
        maj_jz      = 4'h4,
        maj_addm    = 4'h5,
        maj_halt    = 4'hf
    } major_e;

    // alu operations, operand one is always the accumulator
    typedef enum logic [op_w-1:0] {
        op_add, op_sub, op_mul, op_div,
        // single-operand shifts and rotates
        op_shl1, op_shr1, op_rol1, op_ror1,
        op_and, op_or, op_xor, op_nor,
        op_nand, op_xnor,
        // compares give 1 or 0
        op_gt, op_eq
    } alu_op_e;

    // alu format: class, operation, zero-extended immediate
    typedef struct packed {
        major_e           major;
        alu_op_e          op;
        logic [imm_w-1:0] imm;
    } alu_fmt_t;

    // memory and jump format: class and word address
    typedef struct packed {
        major_e                     major;
        logic [bus_pkg::addr_w-1:0] addr;
    } mem_fmt_t;

    // same word seen both ways, the class picks the view
    typedef union packed {
        alu_fmt_t alu;
        mem_fmt_t mem;
    } instr_t;

    // decoded controls for execute, result and the sequencer
    typedef struct packed {
        major_e                     major;
        alu_op_e                    alu_op;
        logic                       use_imm;
        logic [imm_w-1:0]           imm;
        logic [bus_pkg::addr_w-1:0] addr;
        // a data bus cycle follows execute
        logic                       needs_mem;
        logic                       mem_write;
        logic                       writes_acc;
        logic                       is_jump;
        logic                       is_jz;
        logic                       is_halt;
    } ctrl_t;

endpackage

/* design/result_stage.sv */
`timescale 1ns/1ns

module result_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          commit,
    input  isa_pkg::ctrl_t                ctrl,
    input  logic [bus_pkg::data_w-1:0]    alu_result,
    output logic [bus_pkg::data_w-1:0]    acc,
    output logic [bus_pkg::addr_w-1:0]    pc,
    output logic                          halted
);

    // redirect pc to the instruction's address
    logic take_branch;

    // jz looks at acc before this commit
    // it never writes acc itself
    assign take_branch = ctrl.is_jump || (ctrl.is_jz && (acc == '0));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc    <= '0;
            pc     <= '0;
            halted <= 1'b0;
        end else if (commit) begin
            // alu, load and addm results
            if (ctrl.writes_acc) begin
                acc <= alu_result;
            end

            if (take_branch) begin
                pc <= ctrl.addr;
            end else begin
                // 12-bit counter, 4095 wraps to 0
                pc <= pc + 1'b1;
            end

            // sticky until reset
            if (ctrl.is_halt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* verification/acc_cpu_tb.sv */
`timescale 1ns/1ns

module acc_cpu_tb;

    localparam int n_instr    = 200;
    localparam int mem_words  = 1 << bus_pkg::addr_w;
    // data words live well away from the code
    localparam int data_base  = 'h800;
    localparam int clk_period = 4;
    localparam int reset_cyc  = 16;
    localparam int tail_cyc   = 20;
    // 14 cycles covers a fetch and a data cycle with three wait states each
    localparam int limit_ns   = (n_instr * 14 + reset_cyc + tail_cyc) * clk_period;

    logic             clk;
    logic             rst_n;
    logic             stall;
    logic             halted;
    bus_pkg::wb_req_t wb_req;
    bus_pkg::wb_rsp_t wb_rsp;

    logic [31:0]                lcg_state;
    logic [bus_pkg::data_w-1:0] model_mem [0:mem_words-1];
    // expected bus cycles in order
    bus_pkg::wb_req_t           exp_q [$];
    // request as seen in the previous cycle of an open transfer
    bus_pkg::wb_req_t           held;
    logic                       held_valid;
    logic                       ack_seen;
    int                         stall_run;
    int                         n_checked;
    int                         fetch_errs;
    int                         store_errs;
    int                         stable_errs;
    int                         proto_errs;

    acc_cpu u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .halted (halted)
    );

    tb_memory u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .stall  (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // 32-bit lcg returning the upper half
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic int rand_below(input int n);
        logic [15:0] r;
        r = next_rand();
        return int'(r) % n;
    endfunction

    // odd multiplier keeps every address distinct
    function automatic logic [15:0] fill_word(input logic [11:0] a);
        logic [15:0] w;
        w = {4'h0, a};
        return w * 16'h9e37 + 16'h1357;
    endfunction

    // reference alu with the accumulator as operand one
    function automatic logic [15:0] model_alu(input logic [3:0] op, input logic [15:0] a,
                                              input logic [15:0] b);
        logic [31:0] wide;
        wide = {16'h0000, a} * {16'h0000, b};
        case (op)
            4'd0:    return a + b;
            4'd1:    return a + ~b + 16'd1;
            4'd2:    return wide[15:0];
            4'd3:    return (b == 16'd0) ? 16'hffff : a / b;
            4'd4:    return a << 1;
            4'd5:    return a >> 1;
            4'd6:    return (a << 1) | (a >> 15);
            4'd7:    return (a >> 1) | (a << 15);
            4'd8:    return a & b;
            4'd9:    return a | b;
            4'd10:   return a ^ b;
            4'd11:   return ~(a | b);
            4'd12:   return ~(a & b);
            4'd13:   return ~(a ^ b);
            4'd14:   return {15'd0, a > b};
            default: return {15'd0, a == b};
        endcase
    endfunction

    // random program of forward jumps only that ends in store and halt
    task automatic gen_program();
        int          kind;
        int          target;
        logic [3:0]  op;
        logic [7:0]  imm;
        logic [11:0] daddr;
        logic [15:0] word;
        for (int a = 0; a < mem_words; a++) begin
            word = fill_word(12'(a));
            if (a < n_instr - 2) begin
                kind   = rand_below(20);
                op     = 4'(rand_below(16));
                daddr  = 12'(data_base + rand_below(64));
                target = a + 1 + rand_below(6);
                if (target > n_instr - 2) target = n_instr - 2;
                // small immediates make eq, gt and jz outcomes vary
                imm = (rand_below(2) == 0) ? 8'(rand_below(4)) : 8'(rand_below(256));
                if (op == 4'd3 && rand_below(2) == 0) imm = 8'h00;
                if (kind < 9) begin
                    word = {4'h0, op, imm};
                end else if (kind < 11) begin
                    word = {4'h1, daddr};
                end else if (kind < 14) begin
                    word = {4'h2, daddr};
                end else if (kind < 15) begin
                    word = {4'h3, 12'(target)};
                end else if (kind < 17) begin
                    word = {4'h4, 12'(target)};
                end else if (kind < 19) begin
                    word = {4'h5, daddr};
                end else begin
                    // unassigned classes 6 to 14
                    word = {4'(6 + rand_below(9)), 12'(rand_below(mem_words))};
                end
            end else if (a == n_instr - 2) begin
                word = {4'h2, 12'(data_base)};
            end else if (a == n_instr - 1) begin
                word = 16'hf000;
            end
            model_mem[a] = word;
        end
    endtask

    function automatic bus_pkg::wb_req_t make_req(input logic we, input logic [11:0] adr,
                                                  input logic [15:0] dat);
        return '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    endfunction

    // steps the isa from pc 0 and queues every bus cycle it implies
    task automatic run_model();
        logic [11:0] pc;
        logic [15:0] acc;
        logic [15:0] w;
        int          steps;
        pc    = 12'h000;
        acc   = 16'h0000;
        w     = 16'h0000;
        steps = 0;
        while (steps <= 4 * n_instr) begin
            exp_q.push_back(make_req(1'b0, pc, 16'h0000));
            w = model_mem[pc];
            steps++;
            if (w[15:12] == 4'hf) break;
            // jumps below overwrite the default advance
            pc = pc + 12'd1;
            case (w[15:12])
                4'h0: acc = model_alu(w[11:8], acc, {8'h00, w[7:0]});
                4'h1: begin
                    exp_q.push_back(make_req(1'b0, w[11:0], 16'h0000));
                    acc = model_mem[w[11:0]];
                end
                4'h2: begin
                    exp_q.push_back(make_req(1'b1, w[11:0], acc));
                    model_mem[w[11:0]] = acc;
                end
                4'h3: pc = w[11:0];
                4'h4: if (acc == 16'h0000) pc = w[11:0];
                4'h5: begin
                    exp_q.push_back(make_req(1'b0, w[11:0], 16'h0000));
                    acc = acc + model_mem[w[11:0]];
                end
                default: ;
            endcase
        end
    endtask

    // instruction fetch or data read
    task automatic check_fetch(input bus_pkg::wb_req_t exp, input bus_pkg::wb_req_t got);
        n_checked++;
        if (got.adr !== exp.adr) begin
            $display("mismatch wb_req.adr: expected 0x%h got 0x%h", exp.adr, got.adr);
            fetch_errs++;
        end
        if (got.we !== 1'b0) begin
            $display("mismatch wb_req.we: expected 0x0 got 0x%h", got.we);
            fetch_errs++;
        end
    endtask

    task automatic check_store(input bus_pkg::wb_req_t exp, input bus_pkg::wb_req_t got);
        n_checked++;
        if (got.adr !== exp.adr) begin
            $display("mismatch wb_req.adr: expected 0x%h got 0x%h", exp.adr, got.adr);
            store_errs++;
        end
        if (got.we !== 1'b1) begin
            $display("mismatch wb_req.we: expected 0x1 got 0x%h", got.we);
            store_errs++;
        end
        if (got.dat !== exp.dat) begin
            $display("mismatch wb_req.dat: expected 0x%h got 0x%h", exp.dat, got.dat);
            store_errs++;
        end
    endtask

    // whole request must hold through wait states
    task automatic check_stable(input bus_pkg::wb_req_t hold, input bus_pkg::wb_req_t got);
        if (got !== hold) begin
            $display("mismatch wb_req in wait state: expected 0x%h got 0x%h", hold, got);
            stable_errs++;
        end
    endtask

    task automatic check_transfer(input bus_pkg::wb_req_t got);
        bus_pkg::wb_req_t exp;
        if (exp_q.size() == 0) begin
            $display("bus cycle at adr 0x%h has no counterpart in the model", got.adr);
            proto_errs++;
        end else begin
            exp = exp_q.pop_front();
            if (exp.we) check_store(exp, got);
            else check_fetch(exp, got);
        end
    endtask

    // bus sampled mid-cycle where every field has settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_req.cyc !== wb_req.stb) begin
                $display("cyc and stb differ at %0t", $time);
                proto_errs++;
            end
            if (ack_seen && wb_req.stb) begin
                $display("stb still high in the cycle after ack at %0t", $time);
                proto_errs++;
            end
            if (halted && wb_req.stb) begin
                $display("bus cycle started after halt at %0t", $time);
                proto_errs++;
            end
            if (held_valid && !wb_req.stb) begin
                $display("stb dropped before ack at %0t", $time);
                proto_errs++;
                held_valid = 1'b0;
            end
            ack_seen = 1'b0;
            if (wb_req.stb) begin
                if (held_valid) check_stable(held, wb_req);
                held       = wb_req;
                held_valid = 1'b1;
                // ack high here completes the transfer on the next edge
                if (wb_rsp.ack) begin
                    check_transfer(wb_req);
                    held_valid = 1'b0;
                    ack_seen   = 1'b1;
                end
            end
        end
    end

    // random wait states at most three in a row
    always @(posedge clk) begin
        if (stall_run >= 3 || rand_below(2) == 0) begin
            stall    <= 1'b0;
            stall_run = 0;
        end else begin
            stall    <= 1'b1;
            stall_run = stall_run + 1;
        end
    end

    initial begin
        #(limit_ns);
        $display("timeout after %0d ns without reaching halt", limit_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        stall       = 1'b0;
        lcg_state   = 32'd21;
        held_valid  = 1'b0;
        ack_seen    = 1'b0;
        stall_run   = 0;
        n_checked   = 0;
        fetch_errs  = 0;
        store_errs  = 0;
        stable_errs = 0;
        proto_errs  = 0;
        gen_program();
        // slave gets the image before the model writes its own copy
        for (int a = 0; a < mem_words; a++) begin
            u_mem.mem[a] <= model_mem[a];
        end
        run_model();
        repeat (reset_cyc) @(posedge clk);
        if (wb_req.cyc !== 1'b0 || wb_req.stb !== 1'b0 || halted !== 1'b0) begin
            $display("cyc, stb or halted not low during reset");
            proto_errs++;
        end
        rst_n <= 1'b1;
        wait (halted === 1'b1);
        // quiet period where the monitor flags any new stb
        repeat (tail_cyc) @(posedge clk);
        if (halted !== 1'b1) begin
            $display("halted fell after the halt instruction");
            proto_errs++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected bus cycles never appeared", exp_q.size());
            proto_errs++;
        end
        $display("summary: %0d transfers, errors fetch %0d store %0d stable %0d protocol %0d",
                 n_checked, fetch_errs, store_errs, stable_errs, proto_errs);
        if (fetch_errs + store_errs + stable_errs + proto_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verification/tb_memory.sv */
`timescale 1ns/1ns

module tb_memory (
    input  logic             clk,
    input  logic             rst_n,
    input  bus_pkg::wb_req_t wb_req,
    output bus_pkg::wb_rsp_t wb_rsp,
    // high holds off ack for that cycle
    input  logic             stall
);

    // word storage, loaded by the testbench before reset release
    logic [bus_pkg::data_w-1:0] mem [0:(1 << bus_pkg::addr_w)-1];
    logic                       ack_q;
    logic [bus_pkg::data_w-1:0] rdat_q;
    // open cycle not yet acknowledged
    logic                       pending;

    assign pending    = wb_req.cyc && wb_req.stb && !ack_q;
    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdat_q;

    // single-cycle ack, wait states while stall is high
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= pending && !stall;
        end
    end

    // write lands on the ack edge
    // read data registered together with ack
    always @(posedge clk) begin
        if (pending && !stall) begin
            if (wb_req.we) begin
                mem[wb_req.adr] <= wb_req.dat;
            end else begin
                rdat_q <= mem[wb_req.adr];
            end
        end
    end

endmodule
